// File: Makefile
VERILATOR  ?= verilator
TOP        ?= proc_tb
RTL_TOP    ?= proc
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
verilog/isa_pkg.sv
verilog/dp_pkg.sv
verilog/reg_file.sv
verilog/memory2c.sv
verilog/instr_decode.sv
verilog/alu_operand_decode.sv
verilog/alu.sv
verilog/proc.sv
verif/proc_tb.sv

// File: verif/proc_tb.sv
module proc_tb
   import isa_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int MEM_WORDS      = 256;
   localparam int IDX_W          = $clog2(MEM_WORDS);
   localparam int PROG_WORDS     = 60;
   localparam int TIMEOUT_CYCLES = 200;
   localparam int HALT_HOLD      = 20;

   logic                 clk;
   logic                 rst;
   logic                 load_en;
   logic [7:0]           load_addr;
   logic [INSTR_W-1:0]   load_data;
   logic                 retire_valid;
   logic [INSTR_W-1:0]   retire_pc;
   logic                 retire_wr;
   logic [REG_SEL_W-1:0] retire_reg;
   logic [INSTR_W-1:0]   retire_data;
   logic                 st_en;
   logic [INSTR_W-1:0]   st_addr;
   logic [INSTR_W-1:0]   st_data;
   logic                 halted;
   logic                 err;

   // Program image and opcode draw table, weighted toward ALU work
   logic [INSTR_W-1:0] prog [64];
   opcode_t op_table [14] = '{OP_NOP, OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI, OP_ST, OP_LD,
                              OP_SLBI, OP_LBI, OP_RALU, OP_RALU, OP_ADDI, OP_SUBI, OP_LD};
   int seed;

   // Reference model state
   logic [INSTR_W-1:0]   mregs [8];
   logic [INSTR_W-1:0]   mmem [MEM_WORDS];
   logic                 mvalid [MEM_WORDS];
   // Expected record of the last modeled instruction
   logic                 m_wr;
   logic [REG_SEL_W-1:0] m_reg;
   logic [INSTR_W-1:0]   m_data;
   logic                 m_st;
   logic [INSTR_W-1:0]   m_addr;
   logic [INSTR_W-1:0]   m_sdata;
   logic                 m_err;
   logic                 m_halt;

   proc #(.MEM_WORDS(MEM_WORDS)) u_proc (
      .clk(clk), .rst(rst), .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
      .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_wr(retire_wr),
      .retire_reg(retire_reg), .retire_data(retire_data), .st_en(st_en), .st_addr(st_addr),
      .st_data(st_data), .halted(halted), .err(err)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic fail_run;
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic check_val(input string name, input logic [INSTR_W-1:0] got,
                            input logic [INSTR_W-1:0] exp);
      assert (got === exp) else begin
         $display("MISMATCH %s: got %h, expected %h", name, got, exp);
         fail_run();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      assert (got === exp) else begin
         $display("MISMATCH %s: got %h, expected %h", name, got, exp);
         fail_run();
      end
   endtask

   function automatic logic is_legal(input logic [OPC_W-1:0] opc);
      return opc inside {OP_HALT, OP_NOP, OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI,
                         OP_ST, OP_LD, OP_SLBI, OP_LBI, OP_RALU};
   endfunction

   // rs plus sign-extended imm5
   function automatic logic [INSTR_W-1:0] mem_addr(input logic [INSTR_W-1:0] ins);
      return mregs[ins[RS_HI:RS_LO]] + {{11{ins[4]}}, ins[4:0]};
   endfunction

   // Byte address to word, bit 0 dropped, wraps at depth
   function automatic logic [IDX_W-1:0] word_idx(input logic [INSTR_W-1:0] addr);
      return addr[IDX_W:1];
   endfunction

   task automatic reset_model;
      mregs  = '{default: '0};
      mmem   = '{default: '0};
      mvalid = '{default: 1'b0};
   endtask

   task automatic set_write(input logic [REG_SEL_W-1:0] r, input logic [INSTR_W-1:0] d);
      m_wr   = 1'b1;
      m_reg  = r;
      m_data = d;
   endtask

   // One instruction of the ISA, register and memory updates included
   task automatic model_step(input logic [INSTR_W-1:0] ins);
      logic [INSTR_W-1:0] a;
      logic [INSTR_W-1:0] b;
      logic [INSTR_W-1:0] s5;
      logic [INSTR_W-1:0] z5;
      logic [IDX_W-1:0]   widx;
      a      = mregs[ins[RS_HI:RS_LO]];
      b      = mregs[ins[RT_HI:RT_LO]];
      s5     = {{11{ins[4]}}, ins[4:0]};
      z5     = {11'b0, ins[4:0]};
      widx   = word_idx(mem_addr(ins));
      m_wr   = 1'b0;
      m_st   = 1'b0;
      m_err  = 1'b0;
      m_halt = 1'b0;
      case (ins[OPC_HI:OPC_LO])
         OP_HALT:  m_halt = 1'b1;
         OP_NOP: begin
         end
         OP_ADDI:  set_write(ins[RT_HI:RT_LO], a + s5);
         // Immediate minus rs
         OP_SUBI:  set_write(ins[RT_HI:RT_LO], s5 - a);
         OP_XORI:  set_write(ins[RT_HI:RT_LO], a ^ z5);
         OP_ANDNI: set_write(ins[RT_HI:RT_LO], a & ~z5);
         OP_ST: begin
            m_st    = 1'b1;
            m_addr  = mem_addr(ins);
            m_sdata = b;
         end
         OP_LD:    set_write(ins[RT_HI:RT_LO], mmem[widx]);
         // I2 format writes the rs field
         OP_SLBI:  set_write(ins[RS_HI:RS_LO], (a << 8) | {8'b0, ins[7:0]});
         OP_LBI:   set_write(ins[RS_HI:RS_LO], {{8{ins[7]}}, ins[7:0]});
         OP_RALU: begin
            case (ins[1:0])
               2'd0:    set_write(ins[RD_HI:RD_LO], a + b);
               2'd1:    set_write(ins[RD_HI:RD_LO], b - a);
               2'd2:    set_write(ins[RD_HI:RD_LO], a ^ b);
               default: set_write(ins[RD_HI:RD_LO], a & ~b);
            endcase
         end
         default:  m_err = 1'b1;
      endcase
      if (m_wr) begin
         mregs[m_reg] = m_data;
      end
      if (m_st) begin
         mmem[widx]   = b;
         mvalid[widx] = 1'b1;
      end
   endtask

   // Random body, HALT in the last word
   task automatic gen_program;
      logic [INSTR_W-1:0] ins;
      logic [3:0]         draw;
      logic [5:0]         slot;
      logic [OPC_W-1:0]   opc;
      reset_model();
      slot = '0;
      while (slot < 6'(PROG_WORDS - 1)) begin
         draw = 4'($random(seed));
         ins  = 16'($random(seed));
         if (draw >= 4'd14) begin
            do begin
               opc = 5'($random(seed));
            end while (is_legal(opc));
            ins[OPC_HI:OPC_LO] = opc;
         end else begin
            ins[OPC_HI:OPC_LO] = op_table[draw];
         end
         // Never load a word nobody stored
         if (ins[OPC_HI:OPC_LO] == OP_LD && !mvalid[word_idx(mem_addr(ins))]) begin
            ins[OPC_HI:OPC_LO] = OP_ST;
         end
         prog[slot] = ins;
         model_step(ins);
         slot = slot + 6'd1;
         // Reload from the same base and offset, into a random register
         if (ins[OPC_HI:OPC_LO] == OP_ST && slot < 6'(PROG_WORDS - 1)) begin
            ins = {OP_LD, ins[RS_HI:RS_LO], 3'($random(seed)), ins[4:0]};
            prog[slot] = ins;
            model_step(ins);
            slot = slot + 6'd1;
         end
      end
      prog[PROG_WORDS-1] = {OP_HALT, 11'($random(seed))};
   endtask

   task automatic check_retire(input logic [INSTR_W-1:0] pc_exp);
      check_bit("retire_valid", retire_valid, 1'b1);
      check_bit("halted", halted, 1'b0);
      check_val("retire_pc", retire_pc, pc_exp);
      model_step(prog[pc_exp[6:1]]);
      check_bit("err", err, m_err);
      check_bit("retire_wr", retire_wr, m_wr);
      if (m_wr) begin
         check_val("retire_reg", 16'(retire_reg), 16'(m_reg));
         check_val("retire_data", retire_data, m_data);
      end
      check_bit("st_en", st_en, m_st);
      if (m_st) begin
         check_val("st_addr", st_addr, m_addr);
         check_val("st_data", st_data, m_sdata);
      end
   endtask

   initial begin
      int                 cycles;
      logic               done;
      logic [INSTR_W-1:0] exp_pc;
      rst       = 1'b1;
      load_en   = 1'b0;
      load_addr = '0;
      load_data = '0;
      seed      = 71;
      gen_program();
      // One program word per cycle while rst is high
      for (int i = 0; i < PROG_WORDS; i++) begin
         @(negedge clk);
         load_en   = 1'b1;
         load_addr = 8'(i);
         load_data = prog[6'(i)];
      end
      @(negedge clk);
      load_en = 1'b0;
      // Reset holds 8 cycles past the load
      repeat (8) @(negedge clk);
      check_bit("retire_valid", retire_valid, 1'b0);
      check_bit("retire_wr", retire_wr, 1'b0);
      check_bit("st_en", st_en, 1'b0);
      check_bit("halted", halted, 1'b0);
      check_bit("err", err, 1'b0);
      rst = 1'b0;
      reset_model();
      exp_pc = '0;
      done   = 1'b0;
      cycles = 0;
      // Outputs sampled 1 ns after the falling edge
      #1;
      while (!done) begin
         if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: no HALT retired within %0d cycles", TIMEOUT_CYCLES);
            fail_run();
         end
         check_retire(exp_pc);
         if (m_halt) begin
            done = 1'b1;
         end else begin
            exp_pc = exp_pc + 16'd2;
            @(negedge clk);
            #1;
         end
         cycles++;
      end
      // halted follows on the very next edge
      @(negedge clk);
      #1;
      // Frozen core, pc parked on the HALT word
      repeat (HALT_HOLD) begin
         check_bit("halted", halted, 1'b1);
         check_bit("retire_valid", retire_valid, 1'b0);
         check_bit("retire_wr", retire_wr, 1'b0);
         check_bit("st_en", st_en, 1'b0);
         check_val("retire_pc", retire_pc, exp_pc);
         @(negedge clk);
         #1;
      end
      $display("Everything OK");
      $finish;
   end

endmodule

// File: verilog/alu.sv
module alu
   import isa_pkg::*;
   import dp_pkg::*;
(
   input  logic [INSTR_W-1:0] a,
   input  logic [INSTR_W-1:0] b,
   input  alu_op_t            op,
   output logic [INSTR_W-1:0] result
);

   // Shift distance for SLBI
   localparam int BYTE_W = 8;

   always_comb begin
      case (op)
         ALU_ADD: begin
            result = a + b;
         end
         // Reversed subtract, B minus A
         ALU_SUB_BA: begin
            result = b - a;
         end
         ALU_XOR: begin
            result = a ^ b;
         end
         ALU_ANDN: begin
            result = a & ~b;
         end
         // Low byte of B fills in below shifted A
         ALU_SLBI: begin
            result = (a << BYTE_W) | b;
         end
         ALU_PASS_B: begin
            result = b;
         end
         default: begin
            result = '0;
         end
      endcase
   end

endmodule

// File: verilog/alu_operand_decode.sv
module alu_operand_decode
   import isa_pkg::*;
   import dp_pkg::*;
(
   input  logic [INSTR_W-1:0] instr,
   input  imm_sel_t           imm_sel,
   input  logic [INSTR_W-1:0] rs_val,
   input  logic [INSTR_W-1:0] rt_val,
   output logic [INSTR_W-1:0] op_a,
   output logic [INSTR_W-1:0] op_b
);

   logic [IMM5_W-1:0] imm5;
   logic [IMM8_W-1:0] imm8;

   assign imm5 = instr[IMM5_W-1:0];
   assign imm8 = instr[IMM8_W-1:0];

   // A is rs for every format
   assign op_a = rs_val;

   // B is rt or an extended immediate
   always_comb begin
      case (imm_sel)
         IMM_SEXT5: op_b = {{(INSTR_W-IMM5_W){imm5[IMM5_W-1]}}, imm5};
         IMM_ZEXT5: op_b = {{(INSTR_W-IMM5_W){1'b0}}, imm5};
         IMM_SEXT8: op_b = {{(INSTR_W-IMM8_W){imm8[IMM8_W-1]}}, imm8};
         IMM_ZEXT8: op_b = {{(INSTR_W-IMM8_W){1'b0}}, imm8};
         default:   op_b = rt_val;
      endcase
   end

endmodule

// File: verilog/dp_pkg.sv
package dp_pkg;

   // ALU operations, A is always rs
   typedef enum logic [2:0] {
      ALU_ADD    = 3'd0,
      // B minus A
      ALU_SUB_BA = 3'd1,
      ALU_XOR    = 3'd2,
      // A and not B
      ALU_ANDN   = 3'd3,
      // A shifted left 8, or B
      ALU_SLBI   = 3'd4,
      ALU_PASS_B = 3'd5
   } alu_op_t;

   // Write-back source
   typedef enum logic {
      WB_ALU = 1'b0,
      WB_MEM = 1'b1
   } wb_sel_t;

   // Immediate selection for operand B
   typedef enum logic [2:0] {
      IMM_NONE  = 3'd0,
      IMM_SEXT5 = 3'd1,
      IMM_ZEXT5 = 3'd2,
      IMM_SEXT8 = 3'd3,
      IMM_ZEXT8 = 3'd4
   } imm_sel_t;

endpackage

// File: verilog/instr_decode.sv
module instr_decode
   import isa_pkg::*;
   import dp_pkg::*;
(
   input  logic [INSTR_W-1:0]   instr,
   output alu_op_t              alu_op,
   output imm_sel_t             imm_sel,
   // Destination register
   output logic [REG_SEL_W-1:0] wr_sel,
   output logic                 wr_reg,
   output wb_sel_t              wb_sel,
   // Data memory control
   output logic                 mem_en,
   output logic                 mem_wr,
   output logic                 halt,
   output logic                 illegal
);

   opcode_t opcode;
   func_t   func;

   assign opcode = opcode_t'(instr[OPC_HI:OPC_LO]);
   assign func   = func_t'(instr[FUNC_HI:FUNC_LO]);

   always_comb begin
      // Quiet defaults, nothing written
      alu_op  = ALU_ADD;
      imm_sel = IMM_NONE;
      wr_sel  = instr[RT_HI:RT_LO];
      wr_reg  = 1'b0;
      wb_sel  = WB_ALU;
      mem_en  = 1'b0;
      mem_wr  = 1'b0;
      halt    = 1'b0;
      illegal = 1'b0;

      case (opcode)
         OP_HALT: begin
            halt = 1'b1;
         end
         OP_NOP: begin
         end
         // I1 format, result to rt field
         OP_ADDI: begin
            imm_sel = IMM_SEXT5;
            wr_reg  = 1'b1;
         end
         OP_SUBI: begin
            alu_op  = ALU_SUB_BA;
            imm_sel = IMM_SEXT5;
            wr_reg  = 1'b1;
         end
         OP_XORI: begin
            alu_op  = ALU_XOR;
            imm_sel = IMM_ZEXT5;
            wr_reg  = 1'b1;
         end
         OP_ANDNI: begin
            alu_op  = ALU_ANDN;
            imm_sel = IMM_ZEXT5;
            wr_reg  = 1'b1;
         end
         // Address is rs plus imm5
         OP_ST: begin
            imm_sel = IMM_SEXT5;
            mem_en  = 1'b1;
            mem_wr  = 1'b1;
         end
         OP_LD: begin
            imm_sel = IMM_SEXT5;
            mem_en  = 1'b1;
            wr_reg  = 1'b1;
            wb_sel  = WB_MEM;
         end
         // I2 format, result to rs field
         OP_SLBI: begin
            alu_op  = ALU_SLBI;
            imm_sel = IMM_ZEXT8;
            wr_sel  = instr[RS_HI:RS_LO];
            wr_reg  = 1'b1;
         end
         OP_LBI: begin
            alu_op  = ALU_PASS_B;
            imm_sel = IMM_SEXT8;
            wr_sel  = instr[RS_HI:RS_LO];
            wr_reg  = 1'b1;
         end
         // R format, operands rs and rt
         OP_RALU: begin
            wr_sel = instr[RD_HI:RD_LO];
            wr_reg = 1'b1;
            case (func)
               FUNC_ADD:  alu_op = ALU_ADD;
               // rt minus rs
               FUNC_SUB:  alu_op = ALU_SUB_BA;
               FUNC_XOR:  alu_op = ALU_XOR;
               FUNC_ANDN: alu_op = ALU_ANDN;
               default:   alu_op = ALU_ADD;
            endcase
         end
         default: begin
            illegal = 1'b1;
         end
      endcase
   end

endmodule

// File: verilog/isa_pkg.sv
package isa_pkg;

   // Instruction and data words share one width
   localparam int INSTR_W = 16;

   // Eight architectural registers
   localparam int REG_SEL_W = 3;

   // Opcode field
   localparam int OPC_HI = 15;
   localparam int OPC_LO = 11;
   localparam int OPC_W  = OPC_HI - OPC_LO + 1;

   // Register fields
   // rt doubles as rd for I1 format
   localparam int RS_HI = 10;
   localparam int RS_LO = 8;
   localparam int RT_HI = 7;
   localparam int RT_LO = 5;
   // R-format destination
   localparam int RD_HI = 4;
   localparam int RD_LO = 2;

   // R-format function select
   localparam int FUNC_HI = 1;
   localparam int FUNC_LO = 0;
   localparam int FUNC_W  = FUNC_HI - FUNC_LO + 1;

   // Immediates sit in the low bits
   localparam int IMM5_W = 5;
   localparam int IMM8_W = 8;

   typedef enum logic [OPC_W-1:0] {
      OP_HALT  = 5'b00000,
      OP_NOP   = 5'b00001,
      OP_ADDI  = 5'b01000,
      // imm minus rs
      OP_SUBI  = 5'b01001,
      OP_XORI  = 5'b01010,
      OP_ANDNI = 5'b01011,
      OP_ST    = 5'b10000,
      OP_LD    = 5'b10001,
      OP_SLBI  = 5'b10010,
      OP_LBI   = 5'b11000,
      OP_RALU  = 5'b11011
   } opcode_t;

   // Function codes under OP_RALU
   typedef enum logic [FUNC_W-1:0] {
      FUNC_ADD  = 2'd0,
      FUNC_SUB  = 2'd1,
      FUNC_XOR  = 2'd2,
      FUNC_ANDN = 2'd3
   } func_t;

endpackage

// File: verilog/memory2c.sv
module memory2c
   import isa_pkg::*;
#(
   parameter int MEM_WORDS = 256
) (
   input  logic               clk,
   // Byte address
   input  logic [INSTR_W-1:0] addr,
   input  logic               enable,
   input  logic               wr,
   input  logic [INSTR_W-1:0] data_in,
   output logic [INSTR_W-1:0] data_out
);

   // Depth is a power of two
   // Upper address bits wrap
   localparam int IDX_W = $clog2(MEM_WORDS);

   logic [INSTR_W-1:0] mem [MEM_WORDS];
   logic [IDX_W-1:0]   idx;

   // Word index
   // Bit 0 of a byte address is dropped
   assign idx = addr[IDX_W:1];

   // Store on the edge
   always_ff @(posedge clk) begin
      if (enable && wr) begin
         mem[idx] <= data_in;
      end
   end

   // Combinational read, zero when idle
   assign data_out = enable ? mem[idx] : '0;

endmodule

// File: verilog/proc.sv
module proc
   import isa_pkg::*;
   import dp_pkg::*;
#(
   parameter int MEM_WORDS = 256
) (
   input  logic                 clk,
   input  logic                 rst,
   // Program loader, used only during reset
   input  logic                 load_en,
   input  logic [7:0]           load_addr,
   input  logic [INSTR_W-1:0]   load_data,
   // Retire record for the current instruction
   output logic                 retire_valid,
   output logic [INSTR_W-1:0]   retire_pc,
   output logic                 retire_wr,
   output logic [REG_SEL_W-1:0] retire_reg,
   output logic [INSTR_W-1:0]   retire_data,
   // Store strobe
   output logic                 st_en,
   output logic [INSTR_W-1:0]   st_addr,
   output logic [INSTR_W-1:0]   st_data,
   output logic                 halted,
   output logic                 err
);

   logic [INSTR_W-1:0]   pc;
   logic [INSTR_W-1:0]   instr;
   logic [INSTR_W-1:0]   imem_addr;
   logic                 imem_load;
   logic                 exec_en;
   // Decode outputs
   alu_op_t              alu_op;
   imm_sel_t             imm_sel;
   wb_sel_t              wb_sel;
   logic [REG_SEL_W-1:0] wr_sel;
   logic                 wr_reg;
   logic                 mem_en;
   logic                 mem_wr;
   logic                 halt;
   logic                 illegal;
   // Datapath
   logic [INSTR_W-1:0]   rs_val;
   logic [INSTR_W-1:0]   rt_val;
   logic [INSTR_W-1:0]   op_a;
   logic [INSTR_W-1:0]   op_b;
   logic [INSTR_W-1:0]   alu_result;
   logic [INSTR_W-1:0]   dmem_rdata;
   logic [INSTR_W-1:0]   wb_data;
   logic                 rf_wr;
   logic                 dmem_wr;

   // Core runs when out of reset and not halted
   assign exec_en = ~rst & ~halted;

   // pc holds at the HALT address once halted
   always_ff @(posedge clk) begin
      if (rst) begin
         pc     <= '0;
         halted <= 1'b0;
      end else if (exec_en) begin
         if (halt) begin
            halted <= 1'b1;
         end else begin
            pc <= pc + INSTR_W'(2);
         end
      end
   end

   // Loader owns the write port during reset, pc owns the read otherwise
   assign imem_load = rst & load_en;
   assign imem_addr = imem_load ? {{(INSTR_W-9){1'b0}}, load_addr, 1'b0} : pc;

   memory2c #(.MEM_WORDS(MEM_WORDS)) u_imem (
      .clk(clk), .addr(imem_addr), .enable(1'b1), .wr(imem_load),
      .data_in(load_data), .data_out(instr)
   );

   instr_decode u_dec (
      .instr(instr), .alu_op(alu_op), .imm_sel(imm_sel), .wr_sel(wr_sel),
      .wr_reg(wr_reg), .wb_sel(wb_sel), .mem_en(mem_en), .mem_wr(mem_wr),
      .halt(halt), .illegal(illegal)
   );

   // Writes blocked by halt, reset and illegal opcodes
   assign rf_wr   = wr_reg & exec_en & ~illegal;
   assign dmem_wr = mem_wr & exec_en & ~illegal;

   reg_file u_rf (
      .clk(clk), .rst(rst), .rd_sel1(instr[RS_HI:RS_LO]),
      .rd_sel2(instr[RT_HI:RT_LO]), .wr_sel(wr_sel), .wr_data(wb_data),
      .wr(rf_wr), .rd_data1(rs_val), .rd_data2(rt_val)
   );

   alu_operand_decode u_opd (
      .instr(instr), .imm_sel(imm_sel), .rs_val(rs_val), .rt_val(rt_val),
      .op_a(op_a), .op_b(op_b)
   );

   alu u_alu (.a(op_a), .b(op_b), .op(alu_op), .result(alu_result));

   // ALU result is the address, rt carries store data
   memory2c #(.MEM_WORDS(MEM_WORDS)) u_dmem (
      .clk(clk), .addr(alu_result), .enable(mem_en), .wr(dmem_wr),
      .data_in(rt_val), .data_out(dmem_rdata)
   );

   assign wb_data = (wb_sel == WB_MEM) ? dmem_rdata : alu_result;

   // Observation of the instruction retiring this cycle
   assign retire_valid = exec_en;
   assign retire_pc    = pc;
   assign retire_wr    = rf_wr;
   assign retire_reg   = wr_sel;
   assign retire_data  = wb_data;
   assign st_en        = dmem_wr;
   assign st_addr      = alu_result;
   assign st_data      = rt_val;
   assign err          = illegal & exec_en;

endmodule

// File: verilog/reg_file.sv
module reg_file
   import isa_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   // Read ports
   input  logic [REG_SEL_W-1:0] rd_sel1,
   input  logic [REG_SEL_W-1:0] rd_sel2,
   // Write port
   input  logic [REG_SEL_W-1:0] wr_sel,
   input  logic [INSTR_W-1:0]   wr_data,
   input  logic                 wr,
   output logic [INSTR_W-1:0]   rd_data1,
   output logic [INSTR_W-1:0]   rd_data2
);

   localparam int NUM_REGS = 2 ** REG_SEL_W;

   logic [INSTR_W-1:0] regs [NUM_REGS];

   // Write lands on the edge
   // Reads below see it next cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr) begin
         regs[wr_sel] <= wr_data;
      end
   end

   // Asynchronous reads
   // No bypass here, since the write data depends on these reads
   assign rd_data1 = regs[rd_sel1];
   assign rd_data2 = regs[rd_sel2];

endmodule
